//--- hw/nc_pkg.sv
package nc_pkg;

    // bfloat16 format
    localparam int DATA_W   = 16;
    localparam int EXP_W    = 8;
    localparam int MAN_W    = 7;   // Stored mantissa, hidden one not included
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [MAN_W-1:0] man;
    } bf16_t;

    typedef logic [7:0] byte_t;

    // Framing of the byte stream in both directions
    localparam byte_t FRAME_START = 8'hFE;
    localparam byte_t FRAME_END   = 8'hFF;

    // Array geometry
    localparam int ARRAY_N          = 2;
    localparam int OPERAND_CNT      = ARRAY_N * ARRAY_N;
    localparam int FRAME_DATA_BYTES = 2 * OPERAND_CNT * (DATA_W / 8);
    localparam int RESULT_BYTES     = OPERAND_CNT * (DATA_W / 8);

    // First shift up to the edge that captures the results
    localparam int COMPUTE_CYCLES = 6;

    // Index 0 is a1 or b1, which sits in the top bits
    typedef struct packed {
        bf16_t [0:OPERAND_CNT-1] a;
        bf16_t [0:OPERAND_CNT-1] b;
    } operands_t;

    // r1 in the top bits, r4 at the bottom
    typedef bf16_t [0:OPERAND_CNT-1] results_t;

endpackage

//--- hw/bf16_mul.sv
module bf16_mul (
    input  nc_pkg::bf16_t a_i,
    input  nc_pkg::bf16_t b_i,
    output nc_pkg::bf16_t product_o
);
    import nc_pkg::*;

    logic [2*(MAN_W+1)-1:0] prod;      // Significand product, hidden ones included
    logic                   carry;     // Product reached two or more
    logic [MAN_W-1:0]       man;
    logic                   zero;
    logic [EXP_W:0]         exp_sum;   // One extra bit for the raw sum
    logic [EXP_W:0]         exp_unb;
    logic                   overflow;
    logic [EXP_W-1:0]       exp_res;
    logic [MAN_W-1:0]       ovf_mask;

    assign prod  = {1'b1, a_i.man} * {1'b1, b_i.man};
    assign carry = prod[2*MAN_W+1];

    // Drop the leading one, one place further left on a carry
    assign man = carry ? prod[2*MAN_W -: MAN_W] : prod[2*MAN_W-1 -: MAN_W];

    assign zero = (a_i.exp == '0) || (b_i.exp == '0);

    assign exp_sum = {1'b0, a_i.exp} + {1'b0, b_i.exp} + {{EXP_W{1'b0}}, carry};
    assign exp_unb = exp_sum - (EXP_W+1)'(EXP_BIAS);

    // Raw sum outside bias..EXP_MAX saturates, low side included
    assign overflow = !zero && ((exp_sum < EXP_BIAS) || (exp_sum > EXP_MAX));

    always_comb begin
        if (zero) begin
            exp_res = '0;
        end else if (overflow) begin
            exp_res = '1;
        end else begin
            exp_res = exp_unb[EXP_W-1:0];
        end
    end

    assign ovf_mask  = overflow ? '0 : '1;
    assign product_o = {a_i.sign ^ b_i.sign, exp_res, man & ovf_mask};

endmodule

//--- hw/bf16_add.sv
module bf16_add (
    input  nc_pkg::bf16_t a_i,
    input  nc_pkg::bf16_t b_i,
    output nc_pkg::bf16_t sum_o
);
    import nc_pkg::*;

    bf16_t            lead_op;     // Larger magnitude
    bf16_t            lag_op;
    logic             exc;
    logic             same_sign;
    logic [MAN_W:0]   sig_lead;
    logic [MAN_W:0]   sig_lag;
    logic [MAN_W:0]   sig_align;
    logic [EXP_W-1:0] exp_diff;
    logic [MAN_W+1:0] sig_sum;
    logic [MAN_W-1:0] man_res;
    logic [EXP_W-1:0] exp_res;

    // Magnitude order on exponent and mantissa together
    assign {lead_op, lag_op} = (a_i[DATA_W-2:0] < b_i[DATA_W-2:0]) ? {b_i, a_i} : {a_i, b_i};

    assign exc       = (lead_op.exp == EXP_MAX) || (lag_op.exp == EXP_MAX);
    assign same_sign = ~(lead_op.sign ^ lag_op.sign);

    assign sig_lead  = {1'b1, lead_op.man};
    assign sig_lag   = {1'b1, lag_op.man};
    assign exp_diff  = lead_op.exp - lag_op.exp;
    assign sig_align = sig_lag >> exp_diff;

    // No subtract path, unlike signs collapse to zero significand
    assign sig_sum = same_sign ? ({1'b0, sig_lead} + {1'b0, sig_align}) : '0;

    // Carry out moves the point one place
    assign man_res = sig_sum[MAN_W+1] ? sig_sum[MAN_W:1] : sig_sum[MAN_W-1:0];
    assign exp_res = sig_sum[MAN_W+1] ? lead_op.exp + 1'b1 : lead_op.exp;

    assign sum_o = exc ? '0 : {lead_op.sign, exp_res, man_res};

endmodule

//--- hw/processing_element.sv
module processing_element (
    input  logic          clk,
    input  logic          reset,
    input  logic          load_i,
    input  logic          compute_i,
    input  nc_pkg::bf16_t weight_i,
    input  nc_pkg::bf16_t act_i,
    input  nc_pkg::bf16_t psum_i,
    output nc_pkg::bf16_t act_o,
    output nc_pkg::bf16_t psum_o
);
    import nc_pkg::*;

    bf16_t weight_q;    // Stays put for the whole multiply
    bf16_t prod;
    bf16_t sum;

    bf16_mul u_mul (
        .a_i       (act_i),
        .b_i       (weight_q),
        .product_o (prod)
    );

    bf16_add u_add (
        .a_i   (psum_i),
        .b_i   (prod),
        .sum_o (sum)
    );

    always_ff @(posedge clk) begin
        if (load_i) begin
            weight_q <= weight_i;
        end
    end

    // Activations move east, partial sums move south
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            act_o  <= '0;
            psum_o <= '0;
        end else if (compute_i) begin
            act_o  <= act_i;
            psum_o <= sum;
        end
    end

endmodule

//--- hw/systolic_array.sv
module systolic_array (
    input  logic              clk,
    input  logic              reset,
    input  nc_pkg::operands_t operands_i,
    input  logic              operands_valid_i,
    output nc_pkg::results_t  results_o,
    output logic              results_valid_o
);
    import nc_pkg::*;

    typedef enum logic {
        PH_IDLE,
        PH_COMPUTE
    } phase_t;

    phase_t                            phase_q;
    logic [$clog2(COMPUTE_CYCLES)-1:0] cnt_q;
    logic                              load;
    logic                              compute;
    bf16_t act_q   [ARRAY_N][2*ARRAY_N-1];    // Skewed activation rows, slot 0 feeds column 0
    bf16_t delay_q [2*ARRAY_N-1][ARRAY_N];    // Bottom partial sums, slot 0 newest
    bf16_t east_w  [ARRAY_N][ARRAY_N];
    bf16_t south_w [ARRAY_N][ARRAY_N];
    bf16_t act_in  [ARRAY_N][ARRAY_N];
    bf16_t psum_in [ARRAY_N][ARRAY_N];

    // The load phase is the idle cycle that sees operands_valid_i
    assign load    = (phase_q == PH_IDLE) && operands_valid_i;
    assign compute = (phase_q == PH_COMPUTE);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase_q         <= PH_IDLE;
            cnt_q           <= '0;
            results_valid_o <= 1'b0;
        end else begin
            results_valid_o <= 1'b0;
            case (phase_q)
                PH_IDLE: begin
                    if (operands_valid_i) begin
                        phase_q <= PH_COMPUTE;
                        cnt_q   <= '0;
                    end
                end
                PH_COMPUTE: begin
                    if (cnt_q == COMPUTE_CYCLES - 1) begin
                        phase_q         <= PH_IDLE;
                        results_valid_o <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            for (int r = 0; r < ARRAY_N; r++) begin
                for (int k = 0; k < 2 * ARRAY_N - 1; k++) begin
                    act_q[r][k] <= '0;
                end
                for (int c = 0; c < ARRAY_N; c++) begin
                    act_q[r][r + c] <= operands_i.a[r * ARRAY_N + c];   // Row r starts r cycles late
                end
            end
        end else if (compute) begin
            for (int r = 0; r < ARRAY_N; r++) begin
                for (int k = 0; k < 2 * ARRAY_N - 2; k++) begin
                    act_q[r][k] <= act_q[r][k + 1];
                end
                act_q[r][2 * ARRAY_N - 2] <= '0;
            end
            for (int c = 0; c < ARRAY_N; c++) begin
                delay_q[0][c] <= south_w[ARRAY_N - 1][c];
                for (int i = 1; i < 2 * ARRAY_N - 1; i++) begin
                    delay_q[i][c] <= delay_q[i - 1][c];
                end
            end
            // Column c gives its k-th sum k cycles after its first, and starts c cycles late
            if (cnt_q == COMPUTE_CYCLES - 1) begin
                for (int c = 0; c < ARRAY_N; c++) begin
                    for (int k = 0; k < ARRAY_N; k++) begin
                        results_o[c * ARRAY_N + k] <= delay_q[2 * ARRAY_N - 2 - k - c][c];
                    end
                end
            end
        end
    end

    for (genvar r = 0; r < ARRAY_N; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_N; c++) begin : g_col
            if (c == 0) begin : g_west_edge
                assign act_in[r][c] = act_q[r][0];
            end else begin : g_west_inner
                assign act_in[r][c] = east_w[r][c - 1];
            end
            if (r == 0) begin : g_north_edge
                assign psum_in[r][c] = '0;                  // Top row adds to zero
            end else begin : g_north_inner
                assign psum_in[r][c] = south_w[r - 1][c];
            end

            processing_element u_pe (
                .clk       (clk),
                .reset     (reset),
                .load_i    (load),
                .compute_i (compute),
                .weight_i  (operands_i.b[c * ARRAY_N + r]),
                .act_i     (act_in[r][c]),
                .psum_i    (psum_in[r][c]),
                .act_o     (east_w[r][c]),
                .psum_o    (south_w[r][c])
            );
        end
    end

endmodule

//--- hw/frame_receiver.sv
module frame_receiver (
    input  logic              clk,
    input  logic              reset,
    input  nc_pkg::byte_t     rx_data_i,
    input  logic              rx_valid_i,
    output nc_pkg::operands_t operands_o,
    output logic              operands_valid_o,
    output logic              trailer_o
);
    import nc_pkg::*;

    typedef enum logic [1:0] {
        RX_WAIT_START,
        RX_DATA,
        RX_WAIT_END
    } rx_state_t;

    rx_state_t                           state_q;
    logic [$clog2(FRAME_DATA_BYTES)-1:0] cnt_q;    // Data byte position in the frame
    byte_t [0:FRAME_DATA_BYTES-1]        data_q;   // Byte 0 is the high half of a1
    logic                                take;

    assign take = (state_q == RX_DATA) && rx_valid_i;

    // Even counts fill the high half of a number, odd counts the low half
    assign operands_o = data_q;

    always_ff @(posedge clk) begin
        if (take) begin
            data_q[cnt_q] <= rx_data_i;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q          <= RX_WAIT_START;
            cnt_q            <= '0;
            operands_valid_o <= 1'b0;
            trailer_o        <= 1'b0;
        end else begin
            operands_valid_o <= 1'b0;
            trailer_o        <= 1'b0;
            if (rx_valid_i) begin
                case (state_q)
                    RX_WAIT_START: begin
                        if (rx_data_i == FRAME_START) begin   // Anything else is junk
                            state_q <= RX_DATA;
                            cnt_q   <= '0;
                        end
                    end
                    RX_DATA: begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == FRAME_DATA_BYTES - 1) begin
                            operands_valid_o <= 1'b1;
                            state_q          <= RX_WAIT_END;
                        end
                    end
                    RX_WAIT_END: begin
                        if (rx_data_i == FRAME_END) begin
                            trailer_o <= 1'b1;
                            state_q   <= RX_WAIT_START;
                        end
                    end
                    default: state_q <= RX_WAIT_START;
                endcase
            end
        end
    end

endmodule

//--- hw/result_sender.sv
module result_sender (
    input  logic             clk,
    input  logic             reset,
    input  nc_pkg::results_t results_i,
    input  logic             results_valid_i,
    input  logic             trailer_i,
    input  logic             tx_idle_i,
    output nc_pkg::byte_t    tx_data_o,
    output logic             tx_valid_o
);
    import nc_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_SEND
    } tx_state_t;

    tx_state_t                           state_q;
    logic                                res_pend_q;
    logic                                trl_pend_q;
    logic [$clog2(RESULT_BYTES+2)-1:0]   idx_q;      // 0 start byte, last is end byte
    byte_t [0:RESULT_BYTES-1]            res_q;      // Byte 0 is r1 high
    logic                                start;
    logic                                send_now;
    byte_t                               next_byte;

    // Results and trailer may come in either order
    assign start = (state_q == ST_IDLE) && (res_pend_q || results_valid_i) &&
                   (trl_pend_q || trailer_i);

    // Transmitter drops idle the cycle after a pulse, so skip one cycle
    assign send_now = (state_q == ST_SEND) && tx_idle_i && !tx_valid_o;

    always_comb begin
        if (idx_q == '0) begin
            next_byte = FRAME_START;
        end else if (idx_q == RESULT_BYTES + 1) begin
            next_byte = FRAME_END;
        end else begin
            next_byte = res_q[idx_q - 1'b1];
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            res_q <= results_i;
        end
        if (send_now) begin
            tx_data_o <= next_byte;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q    <= ST_IDLE;
            res_pend_q <= 1'b0;
            trl_pend_q <= 1'b0;
            idx_q      <= '0;
            tx_valid_o <= 1'b0;
        end else begin
            tx_valid_o <= send_now;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        res_pend_q <= 1'b0;
                        trl_pend_q <= 1'b0;
                        idx_q      <= '0;
                        state_q    <= ST_SEND;
                    end else begin
                        res_pend_q <= res_pend_q | results_valid_i;
                        trl_pend_q <= trl_pend_q | trailer_i;
                    end
                end
                ST_SEND: begin                      // Strobes are dropped while sending
                    if (send_now) begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == RESULT_BYTES + 1) begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/neural_chip.sv
module neural_chip (
    input  logic          clk,
    input  logic          reset,
    input  nc_pkg::byte_t rx_data_i,
    input  logic          rx_valid_i,
    input  logic          tx_idle_i,
    output nc_pkg::byte_t tx_data_o,
    output logic          tx_valid_o,
    output logic          mult_done_o
);
    import nc_pkg::*;

    operands_t operands;
    logic      operands_valid;
    logic      trailer;
    results_t  results;
    logic      results_valid;

    // Byte stream in, operand set out
    frame_receiver u_frame_receiver (
        .clk              (clk),
        .reset            (reset),
        .rx_data_i        (rx_data_i),
        .rx_valid_i       (rx_valid_i),
        .operands_o       (operands),
        .operands_valid_o (operands_valid),
        .trailer_o        (trailer)
    );

    systolic_array u_systolic_array (
        .clk              (clk),
        .reset            (reset),
        .operands_i       (operands),
        .operands_valid_i (operands_valid),
        .results_o        (results),
        .results_valid_o  (results_valid)
    );

    // Reply frame goes out once both results and trailer are in
    result_sender u_result_sender (
        .clk             (clk),
        .reset           (reset),
        .results_i       (results),
        .results_valid_i (results_valid),
        .trailer_i       (trailer),
        .tx_idle_i       (tx_idle_i),
        .tx_data_o       (tx_data_o),
        .tx_valid_o      (tx_valid_o)
    );

    assign mult_done_o = results_valid;

endmodule

//--- test/bf16_model.svh
`ifndef BF16_MODEL_SVH
`define BF16_MODEL_SVH

// Truncating multiply where an exponent out of range saturates to all ones
function automatic bf16_t model_mul(bf16_t x, bf16_t y);
    logic [15:0] prod;
    int          exp_raw;
    bf16_t       res;
    prod     = {1'b1, x.man} * {1'b1, y.man};
    res.sign = x.sign ^ y.sign;
    res.man  = prod[15] ? prod[14:8] : prod[13:7];
    exp_raw  = int'(x.exp) + int'(y.exp) + int'(prod[15]);
    if (x.exp == 0 || y.exp == 0) begin
        res.exp = '0;                       // Mantissa is kept as is
    end else if (exp_raw < EXP_BIAS || exp_raw > EXP_MAX) begin
        res.exp = '1;
        res.man = '0;
    end else begin
        res.exp = 8'(exp_raw - EXP_BIAS);
    end
    return res;
endfunction

// Add with the simplified rules and no subtract path
function automatic bf16_t model_add(bf16_t x, bf16_t y);
    bf16_t      big;
    bf16_t      lesser;
    logic [7:0] shift;
    logic [8:0] total;
    bf16_t      res;
    if (x.exp == EXP_MAX || y.exp == EXP_MAX) begin
        return '0;
    end
    big    = ({y.exp, y.man} > {x.exp, x.man}) ? y : x;   // Ties keep x in front
    lesser = ({y.exp, y.man} > {x.exp, x.man}) ? x : y;
    shift  = big.exp - lesser.exp;
    total  = (big.sign == lesser.sign) ? {1'b1, big.man} + ({1'b1, lesser.man} >> shift) : '0;
    res.sign = big.sign;
    res.exp  = total[8] ? big.exp + 8'd1 : big.exp;
    res.man  = total[8] ? total[7:1] : total[6:0];
    return res;
endfunction

// First product goes onto zero, second onto that partial sum
function automatic bf16_t model_dot2(bf16_t x1, bf16_t y1, bf16_t x2, bf16_t y2);
    return model_add(model_add('0, model_mul(x1, y1)), model_mul(x2, y2));
endfunction

function automatic results_t model_matmul(operands_t ops);
    results_t res;
    res[0] = model_dot2(ops.a[0], ops.b[0], ops.a[2], ops.b[1]);
    res[1] = model_dot2(ops.a[1], ops.b[0], ops.a[3], ops.b[1]);
    res[2] = model_dot2(ops.a[0], ops.b[2], ops.a[2], ops.b[3]);
    res[3] = model_dot2(ops.a[1], ops.b[2], ops.a[3], ops.b[3]);
    return res;
endfunction

`endif

//--- test/tb_neural_chip.sv
module tb_neural_chip;
    timeunit 1ns;
    timeprecision 1ps;
    import nc_pkg::*;

    `include "bf16_model.svh"

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int BUSY_LIMIT  = 20;    // Longest transmitter busy time in any test
    localparam int FRAME_COUNT = 14;
    localparam int REPLY_BYTES = RESULT_BYTES + 2;
    localparam int REPLY_WAIT  = REPLY_BYTES * (BUSY_LIMIT + 2) + 100;
    localparam int WATCHDOG_CYCLES =
        FRAME_COUNT * (17 + 10 * (BUSY_LIMIT + 2) + 20) + 200 + 30 + 500;

    logic  clk;
    logic  reset;
    byte_t rx_data_i;
    logic  rx_valid_i;
    logic  tx_idle_i;
    byte_t tx_data_o;
    logic  tx_valid_o;
    logic  mult_done_o;

    int    seed = 16;
    int    busy_min = 1;
    int    busy_max = 1;
    byte_t tx_q[$];             // Bytes taken by the transmitter model
    logic  done_seen = 1'b0;
    event  data_sent_ev;        // Sixteenth data byte is on the port

    neural_chip DUT (
        .clk         (clk),
        .reset       (reset),
        .rx_data_i   (rx_data_i),
        .rx_valid_i  (rx_valid_i),
        .tx_idle_i   (tx_idle_i),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o),
        .mult_done_o (mult_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Transmitter takes a byte, then stays busy for a while
    initial begin
        int busy;
        tx_idle_i = 1'b1;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (tx_valid_o) begin
                tx_q.push_back(tx_data_o);
                busy = busy_min + int'($unsigned($random(seed)) % (busy_max - busy_min + 1));
                tx_idle_i = 1'b0;
                repeat (busy) @(posedge clk);
                #DRIVE_DELAY;
                tx_idle_i = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (mult_done_o) begin
            done_seen = 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_byte(string name, byte_t expected, byte_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s expected %02h, got %02h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_result(string name, bf16_t expected, bf16_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s expected %04h, got %04h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s expected %b, got %b",
                                        $time, name, expected, actual));
        end
    endtask

    // Called and left at 10 ns after a rising edge
    task automatic drive_byte(byte_t value);
        rx_data_i  = value;
        rx_valid_i = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        rx_valid_i = 1'b0;
    endtask

    task automatic send_frame(operands_t ops, int n_data, bit with_trailer);
        logic [8*FRAME_DATA_BYTES-1:0] flat;
        flat = ops;
        drive_byte(FRAME_START);
        for (int i = 0; i < n_data; i++) begin
            if (i == FRAME_DATA_BYTES - 1) begin
                -> data_sent_ev;
            end
            drive_byte(flat[8*FRAME_DATA_BYTES-1-8*i -: 8]);
        end
        if (with_trailer) begin
            drive_byte(FRAME_END);
        end
    endtask

    task automatic wait_reply();
        int cycles;
        cycles = 0;
        while (tx_q.size() < REPLY_BYTES && cycles < REPLY_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_q.size() < REPLY_BYTES) begin
            stop_with_failure("Reply frame did not complete in time");
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_reply(results_t expected);
        logic [8*RESULT_BYTES-1:0] flat;
        flat = expected;
        check_byte("tx_data_o start byte", FRAME_START, tx_q.pop_front());
        for (int i = 0; i < RESULT_BYTES; i++) begin
            check_byte($sformatf("tx_data_o result byte %0d", i),
                       flat[8*RESULT_BYTES-1-8*i -: 8], tx_q.pop_front());
        end
        check_byte("tx_data_o end byte", FRAME_END, tx_q.pop_front());
    endtask

    task automatic check_reply_results(results_t expected);
        byte_t hi;
        byte_t lo;
        check_byte("tx_data_o start byte", FRAME_START, tx_q.pop_front());
        for (int n = 0; n < OPERAND_CNT; n++) begin
            hi = tx_q.pop_front();
            lo = tx_q.pop_front();
            check_result($sformatf("r%0d", n + 1), expected[n], {hi, lo});
        end
        check_byte("tx_data_o end byte", FRAME_END, tx_q.pop_front());
    endtask

    // a = 1, 2, 3, 4 and b = 0.5, 1.5, -2, 2.5
    function automatic operands_t fixed_operands();
        return {16'h3F80, 16'h4000, 16'h4040, 16'h4080,
                16'h3F00, 16'h3FC0, 16'hC000, 16'h4020};
    endfunction

    function automatic bf16_t random_number();
        bf16_t num;
        num.sign = 1'b0;
        num.exp  = 8'(120 + $unsigned($random(seed)) % 15);
        num.man  = 7'($random(seed));
        return num;
    endfunction

    function automatic operands_t random_operands();
        operands_t ops;
        for (int n = 0; n < OPERAND_CNT; n++) begin
            ops.a[n] = random_number();
            ops.b[n] = random_number();
        end
        return ops;
    endfunction

    task automatic check_done_latency();
        @(data_sent_ev);
        repeat (COMPUTE_CYCLES + 1) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_flag("mult_done_o before its cycle", 1'b0, mult_done_o);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        check_flag("mult_done_o", 1'b1, mult_done_o);
    endtask

    task automatic test_fixed_frame();
        operands_t ops;
        ops      = fixed_operands();
        busy_min = 1;
        busy_max = 1;
        fork
            send_frame(ops, FRAME_DATA_BYTES, 1'b1);
            check_done_latency();
        join
        wait_reply();
        check_reply(model_matmul(ops));
    endtask

    task automatic test_leading_junk();
        operands_t ops;
        ops = fixed_operands();
        drive_byte(8'h00);
        drive_byte(8'h55);
        drive_byte(FRAME_END);          // Trailer byte out of place is junk too
        drive_byte(8'hA5);
        send_frame(ops, FRAME_DATA_BYTES, 1'b1);
        wait_reply();
        check_reply(model_matmul(ops));
    endtask

    task automatic test_trailer_gating();
        operands_t ops;
        ops       = random_operands();
        done_seen = 1'b0;
        send_frame(ops, FRAME_DATA_BYTES, 1'b0);
        repeat (200) @(negedge clk);
        check_flag("mult_done_o pulse", 1'b1, done_seen);
        check_flag("tx_valid_o before trailer", 1'b0, tx_q.size() != 0);
        @(posedge clk);
        #DRIVE_DELAY;
        drive_byte(FRAME_END);
        wait_reply();
        check_reply(model_matmul(ops));
    endtask

    task automatic test_back_pressure();
        operands_t ops;
        ops      = random_operands();
        busy_min = 1;
        busy_max = BUSY_LIMIT;
        send_frame(ops, FRAME_DATA_BYTES, 1'b1);
        wait_reply();
        check_reply(model_matmul(ops));
    endtask

    task automatic test_random_frames();
        operands_t ops;
        busy_min = 1;
        busy_max = 3;
        repeat (8) begin
            ops = random_operands();
            send_frame(ops, FRAME_DATA_BYTES, 1'b1);
            wait_reply();
            check_reply_results(model_matmul(ops));
        end
    endtask

    task automatic test_reset_mid_frame();
        operands_t                     ops;
        logic [8*FRAME_DATA_BYTES-1:0] flat;
        ops  = fixed_operands();        // No data byte here equals a frame byte
        flat = ops;
        send_frame(ops, FRAME_DATA_BYTES / 2, 1'b0);
        reset     = 1'b0;
        done_seen = 1'b0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;
        // Without the reset these bytes would finish the broken frame
        for (int i = FRAME_DATA_BYTES / 2; i < FRAME_DATA_BYTES; i++) begin
            drive_byte(flat[8*FRAME_DATA_BYTES-1-8*i -: 8]);
        end
        drive_byte(FRAME_END);
        repeat (30) @(negedge clk);
        check_flag("mult_done_o after reset", 1'b0, done_seen);
        check_flag("tx_valid_o after reset", 1'b0, tx_q.size() != 0);
        @(posedge clk);
        #DRIVE_DELAY;
        ops = random_operands();
        send_frame(ops, FRAME_DATA_BYTES, 1'b1);
        wait_reply();
        check_reply(model_matmul(ops));
    endtask

    initial begin
        reset      = 1'b0;
        rx_data_i  = '0;
        rx_valid_i = 1'b0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;
        test_fixed_frame();
        test_leading_junk();
        test_trailer_gating();
        test_back_pressure();
        test_random_frames();
        test_reset_mid_frame();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- list.f
+incdir+test
hw/nc_pkg.sv
hw/bf16_mul.sv
hw/bf16_add.sv
hw/processing_element.sv
hw/systolic_array.sv
hw/frame_receiver.sv
hw/result_sender.sv
hw/neural_chip.sv
test/tb_neural_chip.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
# The exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
        -f list.f --top-module tb_neural_chip \
        -Mdir obj_dir -o sim_neural_chip; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_neural_chip; then
    echo "Simulation returned a failing status"
    exit 1
fi

exit 0
